// File: Makefile
# Verilator build and run for the HyperBus transceiver testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal
TOP       ?= tb_hyperbus_trx
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, a failure message fails the target
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: hdl/hyperbus_cdc_fifo.sv
/* Asynchronous FIFO with Gray-coded pointers for crossing RX words
   from the RWDS strobe domain into the system clock domain. */

`timescale 1ns/100ps
`default_nettype none

module hyperbus_cdc_fifo #(
    parameter int unsigned LogDepth   = 3,
    parameter int unsigned SyncStages = 2
) (
    input  logic                src_clk_i,
    input  logic                src_rst_ni,
    input  hyperbus_pkg::word_t src_data_i,
    input  logic                src_valid_i,
    output logic                src_ready_o,
    input  logic                dst_clk_i,
    input  logic                dst_rst_ni,
    output hyperbus_pkg::word_t dst_data_o,
    output logic                dst_valid_o,
    input  logic                dst_ready_i
);

    localparam int unsigned Depth = 2 ** LogDepth;
    localparam int unsigned PtrW  = LogDepth + 1;

    typedef logic [PtrW-1:0] ptr_t;

    hyperbus_pkg::word_t mem_q [Depth];

    ptr_t wptr_bin_q;
    ptr_t wptr_gray_q;
    ptr_t rptr_bin_q;
    ptr_t rptr_gray_q;
    ptr_t wptr_bin_next;
    ptr_t rptr_bin_next;
    ptr_t full_cmp;
    logic push;
    logic pop;

    // Synchronizer chains, last stage is the usable copy
    ptr_t [SyncStages-1:0] rptr_sync_q;
    ptr_t [SyncStages-1:0] wptr_sync_q;

    function automatic ptr_t bin2gray(input ptr_t bin);
        return bin ^ (bin >> 1);
    endfunction

    // ============================================================
    // Write side
    // ============================================================

    // Full when the top two Gray bits differ and the rest match
    assign full_cmp      = rptr_sync_q[SyncStages-1] ^ {2'b11, {(PtrW-2){1'b0}}};
    assign src_ready_o   = (wptr_gray_q != full_cmp);
    assign push          = src_valid_i & src_ready_o;
    assign wptr_bin_next = wptr_bin_q + ptr_t'(1);

    always_ff @(posedge src_clk_i) begin
        if (push) begin
            mem_q[wptr_bin_q[LogDepth-1:0]] <= src_data_i;
        end
    end

    always_ff @(posedge src_clk_i or negedge src_rst_ni) begin
        if (!src_rst_ni) begin
            wptr_bin_q  <= '0;
            wptr_gray_q <= '0;
            rptr_sync_q <= '0;
        end else begin
            if (push) begin
                wptr_bin_q  <= wptr_bin_next;
                wptr_gray_q <= bin2gray(wptr_bin_next);
            end
            rptr_sync_q[0] <= rptr_gray_q;
            for (int i = 1; i < SyncStages; i++) begin
                rptr_sync_q[i] <= rptr_sync_q[i-1];
            end
        end
    end

    // ============================================================
    // Read side
    // ============================================================

    assign dst_valid_o   = (rptr_gray_q != wptr_sync_q[SyncStages-1]);
    assign dst_data_o    = mem_q[rptr_bin_q[LogDepth-1:0]];
    assign pop           = dst_valid_o & dst_ready_i;
    assign rptr_bin_next = rptr_bin_q + ptr_t'(1);

    always_ff @(posedge dst_clk_i or negedge dst_rst_ni) begin
        if (!dst_rst_ni) begin
            rptr_bin_q  <= '0;
            rptr_gray_q <= '0;
            wptr_sync_q <= '0;
        end else begin
            if (pop) begin
                rptr_bin_q  <= rptr_bin_next;
                rptr_gray_q <= bin2gray(rptr_bin_next);
            end
            wptr_sync_q[0] <= wptr_gray_q;
            for (int i = 1; i < SyncStages; i++) begin
                wptr_sync_q[i] <= wptr_sync_q[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/hyperbus_ddr_out.sv
/* Single-bit DDR output stage.
   d0_i leaves in the high clock phase, d1_i in the low phase. */

`timescale 1ns/100ps
`default_nettype none

module hyperbus_ddr_out #(
    parameter logic Init = 1'b0
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic d0_i,
    input  logic d1_i,
    output logic q_o
);

    logic d0_q;
    logic d1_q;

    // Both halves are captured together at the rising edge
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            d0_q <= Init;
            d1_q <= Init;
        end else begin
            d0_q <= d0_i;
            d1_q <= d1_i;
        end
    end

    // Clock level selects the half
    assign q_o = clk_i ? d0_q : d1_q;

endmodule

`default_nettype wire

// File: hdl/hyperbus_pkg.sv
/* Shared types and widths for the HyperBus transceiver.
   Every transceiver module refers to these by scoped name. */

`default_nettype none

package hyperbus_pkg;

    // ============================================================
    // Data widths
    // ============================================================

    localparam int unsigned WordWidth = 16;
    localparam int unsigned ByteWidth = 8;

    // Controller word, upper byte travels first on the bus
    typedef logic [WordWidth-1:0] word_t;

    // One DQ byte
    typedef logic [ByteWidth-1:0] byte_t;

    // ============================================================
    // Controller-side control bundles
    // ============================================================

    typedef struct packed {
        logic       clk_ena;
        word_t      data;
        logic       data_oe;
        logic [1:0] rwds;     // Bit 1 goes out in the high phase
        logic       rwds_oe;
    } tx_ctrl_t;

    typedef struct packed {
        logic clk_set;
        logic clk_reset;
    } rx_ctrl_t;

    // ============================================================
    // Pad-side outputs
    // ============================================================

    typedef struct packed {
        logic  ck;
        logic  ck_n;
        logic  rwds;
        logic  rwds_oe;
        byte_t dq;
        logic  dq_oe;
        logic  reset_n;
    } hyper_out_t;

endpackage

`default_nettype wire

// File: hdl/hyperbus_rx.sv
/* HyperBus receive path. Captures DQ on both RWDS edges inside the receive
   window and hands complete words to the system clock through a CDC FIFO. */

`timescale 1ns/100ps
`default_nettype none

module hyperbus_rx #(
    parameter int unsigned RxFifoLogDepth = 3,
    parameter int unsigned SyncStages     = 2
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  hyperbus_pkg::rx_ctrl_t rx_ctrl_i,
    input  logic                   hyper_rwds_i,
    input  hyperbus_pkg::byte_t    hyper_dq_i,
    input  logic                   rx_ready_i,
    output hyperbus_pkg::word_t    rx_data_o,
    output logic                   rx_valid_o,
    output logic                   rx_overflow_o
);

    logic                rx_win_q;
    logic                rwds_rst_n;
    logic                rwds_n;
    hyperbus_pkg::byte_t upper_q;
    logic                armed_q;
    hyperbus_pkg::word_t fifo_wdata;
    logic                fifo_wready;
    logic                ovf_q;
    logic [SyncStages-1:0] ovf_sync_q;

    // Receive window, set wins over reset
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rx_win_q <= 1'b0;
        end else if (rx_ctrl_i.clk_set) begin
            rx_win_q <= 1'b1;
        end else if (rx_ctrl_i.clk_reset) begin
            rx_win_q <= 1'b0;
        end
    end

    // Strobe-side logic is held in reset while the window is closed
    assign rwds_rst_n = rst_ni & rx_win_q;
    assign rwds_n     = ~hyper_rwds_i;

    // ============================================================
    // Strobe domain
    // ============================================================

    always_ff @(posedge hyper_rwds_i) begin
        upper_q <= hyper_dq_i;
    end

    // First falling edge before any rising edge must not write
    always_ff @(posedge hyper_rwds_i or negedge rwds_rst_n) begin
        if (!rwds_rst_n) begin
            armed_q <= 1'b0;
        end else begin
            armed_q <= 1'b1;
        end
    end

    assign fifo_wdata = {upper_q, hyper_dq_i};

    // Sticky, survives window close and only clears on rst_ni
    always_ff @(posedge rwds_n or negedge rst_ni) begin
        if (!rst_ni) begin
            ovf_q <= 1'b0;
        end else if (armed_q && !fifo_wready) begin
            ovf_q <= 1'b1;
        end
    end

    hyperbus_cdc_fifo #(
        .LogDepth   (RxFifoLogDepth),
        .SyncStages (SyncStages)
    ) u_rx_fifo (
        .src_clk_i   (rwds_n),
        .src_rst_ni  (rst_ni),
        .src_data_i  (fifo_wdata),
        .src_valid_i (armed_q),
        .src_ready_o (fifo_wready),
        .dst_clk_i   (clk_i),
        .dst_rst_ni  (rst_ni),
        .dst_data_o  (rx_data_o),
        .dst_valid_o (rx_valid_o),
        .dst_ready_i (rx_ready_i)
    );

    // ============================================================
    // Overflow flag into the system clock
    // ============================================================

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ovf_sync_q <= '0;
        end else begin
            ovf_sync_q[0] <= ovf_q;
            for (int i = 1; i < SyncStages; i++) begin
                ovf_sync_q[i] <= ovf_sync_q[i-1];
            end
        end
    end

    assign rx_overflow_o = ovf_sync_q[SyncStages-1];

endmodule

`default_nettype wire

// File: hdl/hyperbus_trx.sv
/* HyperBus PHY top level. Connects the controller to the pads through
   the TX and RX paths and assembles the pad output bundle. */

`timescale 1ns/100ps
`default_nettype none

module hyperbus_trx #(
    parameter int unsigned NumChips       = 2,
    parameter int unsigned RxFifoLogDepth = 3,
    parameter int unsigned SyncStages     = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // Controller side
    input  logic [NumChips-1:0]      cs_i,
    input  logic                     cs_ena_i,
    input  hyperbus_pkg::tx_ctrl_t   tx_ctrl_i,
    input  logic                     rwds_sample_ena_i,
    output logic                     rwds_sample_o,
    input  hyperbus_pkg::rx_ctrl_t   rx_ctrl_i,
    output hyperbus_pkg::word_t      rx_data_o,
    output logic                     rx_valid_o,
    input  logic                     rx_ready_i,
    output logic                     rx_overflow_o,
    // Pad side
    output logic [NumChips-1:0]      hyper_cs_no,
    output hyperbus_pkg::hyper_out_t hyper_o,
    input  logic                     hyper_rwds_i,
    input  hyperbus_pkg::byte_t      hyper_dq_i
);

    hyperbus_pkg::hyper_out_t tx_hyper;

    // ============================================================
    // Transmit and receive paths
    // ============================================================

    hyperbus_tx #(
        .NumChips (NumChips)
    ) u_tx (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .cs_i              (cs_i),
        .cs_ena_i          (cs_ena_i),
        .tx_ctrl_i         (tx_ctrl_i),
        .rwds_sample_ena_i (rwds_sample_ena_i),
        .hyper_rwds_i      (hyper_rwds_i),
        .hyper_cs_no       (hyper_cs_no),
        .hyper_o           (tx_hyper),
        .rwds_sample_o     (rwds_sample_o)
    );

    hyperbus_rx #(
        .RxFifoLogDepth (RxFifoLogDepth),
        .SyncStages     (SyncStages)
    ) u_rx (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .rx_ctrl_i     (rx_ctrl_i),
        .hyper_rwds_i  (hyper_rwds_i),
        .hyper_dq_i    (hyper_dq_i),
        .rx_ready_i    (rx_ready_i),
        .rx_data_o     (rx_data_o),
        .rx_valid_o    (rx_valid_o),
        .rx_overflow_o (rx_overflow_o)
    );

    // Memory reset follows the system reset
    assign hyper_o = '{
        ck:      tx_hyper.ck,
        ck_n:    tx_hyper.ck_n,
        rwds:    tx_hyper.rwds,
        rwds_oe: tx_hyper.rwds_oe,
        dq:      tx_hyper.dq,
        dq_oe:   tx_hyper.dq_oe,
        reset_n: rst_ni
    };

endmodule

`default_nettype wire

// File: hdl/hyperbus_tx.sv
/* HyperBus transmit path with DDR data, delayed enables, chip selects,
   gated differential bus clock and on-demand RWDS level sampling. */

`timescale 1ns/100ps
`default_nettype none

module hyperbus_tx #(
    parameter int unsigned NumChips = 2
) (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic [NumChips-1:0]      cs_i,
    input  logic                     cs_ena_i,
    input  hyperbus_pkg::tx_ctrl_t   tx_ctrl_i,
    input  logic                     rwds_sample_ena_i,
    input  logic                     hyper_rwds_i,
    output logic [NumChips-1:0]      hyper_cs_no,
    output hyperbus_pkg::hyper_out_t hyper_o,
    output logic                     rwds_sample_o
);

    hyperbus_pkg::byte_t dq_ddr;
    logic                rwds_ddr;
    logic                dq_oe_q;
    logic                rwds_oe_q;
    logic                clk_ena_q;
    logic                ck_gate_q;
    logic                ck;

    // ============================================================
    // DDR data converters
    // ============================================================

    // Upper byte in the high phase, lower byte in the low phase
    for (genvar i = 0; i < hyperbus_pkg::ByteWidth; i++) begin : gen_ddr_dq
        hyperbus_ddr_out #(
            .Init (1'b0)
        ) u_ddr_dq (
            .clk_i  (clk_i),
            .rst_ni (rst_ni),
            .d0_i   (tx_ctrl_i.data[i + hyperbus_pkg::ByteWidth]),
            .d1_i   (tx_ctrl_i.data[i]),
            .q_o    (dq_ddr[i])
        );
    end

    hyperbus_ddr_out #(
        .Init (1'b0)
    ) u_ddr_rwds (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d0_i   (tx_ctrl_i.rwds[1]),
        .d1_i   (tx_ctrl_i.rwds[0]),
        .q_o    (rwds_ddr)
    );

    // ============================================================
    // Enables, chip selects and RWDS sampling
    // ============================================================

    // One cycle of delay keeps the enables in step with the DDR registers
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            dq_oe_q       <= 1'b0;
            rwds_oe_q     <= 1'b0;
            clk_ena_q     <= 1'b0;
            hyper_cs_no   <= '1;
            rwds_sample_o <= 1'b0;
        end else begin
            dq_oe_q     <= tx_ctrl_i.data_oe;
            rwds_oe_q   <= tx_ctrl_i.rwds_oe;
            clk_ena_q   <= tx_ctrl_i.clk_ena;
            hyper_cs_no <= cs_ena_i ? ~cs_i : '1;
            if (rwds_sample_ena_i) begin
                rwds_sample_o <= hyper_rwds_i;
            end
        end
    end

    // Gate term only moves while clk_i is low
    always_ff @(negedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ck_gate_q <= 1'b0;
        end else begin
            ck_gate_q <= clk_ena_q;
        end
    end

    assign ck = clk_i & ck_gate_q;

    always_comb begin
        hyper_o.ck      = ck;
        hyper_o.ck_n    = ~ck;
        hyper_o.rwds    = rwds_ddr;
        hyper_o.rwds_oe = rwds_oe_q;
        hyper_o.dq      = dq_ddr;
        hyper_o.dq_oe   = dq_oe_q;
        hyper_o.reset_n = 1'b1;  // Pad reset is merged in at the top level
    end

endmodule

`default_nettype wire

// File: testbench/tb_hyperbus_trx.sv
/* Self-checking testbench for the HyperBus transceiver. Drives random TX words,
   RWDS sampling and strobed RX bursts from a memory model; assertions check. */

`timescale 1ns/100ps
`default_nettype none

module tb_hyperbus_trx;

    localparam int unsigned NumChips       = 2;
    localparam int unsigned RxFifoLogDepth = 3;
    localparam int unsigned SyncStages     = 2;
    localparam int unsigned Depth          = 2 ** RxFifoLogDepth;
    localparam int unsigned TxCycles       = 300;
    localparam int unsigned RxBursts       = 16;
    localparam int unsigned BurstCycles    = 80;
    localparam int unsigned StimCycles     = 32 + TxCycles + (RxBursts + 3) * BurstCycles;

    logic                     clk_i;
    logic                     rst_ni;
    logic [NumChips-1:0]      cs_i;
    logic                     cs_ena_i;
    hyperbus_pkg::tx_ctrl_t   tx_ctrl_i;
    logic                     rwds_sample_ena_i;
    logic                     rwds_sample_o;
    hyperbus_pkg::rx_ctrl_t   rx_ctrl_i;
    hyperbus_pkg::word_t      rx_data_o;
    logic                     rx_valid_o;
    logic                     rx_ready_i;
    logic                     rx_overflow_o;
    logic [NumChips-1:0]      hyper_cs_no;
    hyperbus_pkg::hyper_out_t hyper_o;
    logic                     hyper_rwds_i;
    hyperbus_pkg::byte_t      hyper_dq_i;

    int unsigned              errors;
    int unsigned              checks;
    string                    test_name;
    hyperbus_pkg::word_t      exp_q [$];
    int unsigned              ready_mode;  // 0 low, 1 random, 2 high

    // Expected-value state of the TX checker
    hyperbus_pkg::tx_ctrl_t   tx_cap;
    logic [NumChips-1:0]      cs_exp;
    logic                     ck_ena_prev;
    logic                     sample_model;

    hyperbus_trx #(
        .NumChips       (NumChips),
        .RxFifoLogDepth (RxFifoLogDepth),
        .SyncStages     (SyncStages)
    ) u_hyperbus_trx (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .cs_i              (cs_i),
        .cs_ena_i          (cs_ena_i),
        .tx_ctrl_i         (tx_ctrl_i),
        .rwds_sample_ena_i (rwds_sample_ena_i),
        .rwds_sample_o     (rwds_sample_o),
        .rx_ctrl_i         (rx_ctrl_i),
        .rx_data_o         (rx_data_o),
        .rx_valid_o        (rx_valid_o),
        .rx_ready_i        (rx_ready_i),
        .rx_overflow_o     (rx_overflow_o),
        .hyper_cs_no       (hyper_cs_no),
        .hyper_o           (hyper_o),
        .hyper_rwds_i      (hyper_rwds_i),
        .hyper_dq_i        (hyper_dq_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    initial begin
        #(40 * StimCycles);
        $display("Watchdog expired after %0d ns, the run did not finish", 40 * StimCycles);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (exp == act) else begin
            errors++;
            $display("** Error %s: %s expected %0h actual %0h", test_name, what, exp, act);
        end
    endtask

    task automatic check_reset_state();
        check_value("hyper_cs_no", {NumChips{1'b1}}, hyper_cs_no);
        check_value("dq_oe", 0, hyper_o.dq_oe);
        check_value("rwds_oe", 0, hyper_o.rwds_oe);
        check_value("ck", 0, hyper_o.ck);
        check_value("rx_valid_o", 0, rx_valid_o);
        check_value("rx_overflow_o", 0, rx_overflow_o);
        check_value("rwds_sample_o", 0, rwds_sample_o);
        check_value("reset_n", rst_ni, hyper_o.reset_n);
    endtask

    // The in-reset look happens with clk_i high so the gated ck is visible
    task automatic apply_reset();
        @(negedge clk_i);
        rst_ni = 1'b0;
        exp_q.delete();
        repeat (7) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        check_reset_state();
        @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        check_reset_state();
    endtask

    task automatic set_window(input logic open);
        @(negedge clk_i);
        rx_ctrl_i.clk_set   = open;
        rx_ctrl_i.clk_reset = !open;
        @(negedge clk_i);
        rx_ctrl_i = '0;
    endtask

    // Memory model, one word per clock, DQ settles 1 ns before each strobe edge
    task automatic strobe_burst(input int unsigned words, input bit expect_words);
        logic [31:0] rnd;
        for (int unsigned i = 0; i < words; i++) begin
            rnd = $urandom;
            @(negedge clk_i);
            #0.5 hyper_dq_i = rnd[15:8];
            #1 hyper_rwds_i = 1'b1;
            #1 hyper_dq_i = rnd[7:0];
            #1 hyper_rwds_i = 1'b0;
            if (expect_words) begin
                exp_q.push_back(rnd[15:0]);
            end
        end
    endtask

    task automatic wait_drain(input int unsigned max_cycles);
        int unsigned n;
        n = 0;
        while (exp_q.size() != 0 && n < max_cycles) begin
            @(negedge clk_i);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d words still missing after %0d cycles",
                     test_name, exp_q.size(), max_cycles);
            exp_q.delete();
        end
    endtask

    task automatic drive_tx(input int unsigned cycles, input int unsigned sample_odds);
        logic [31:0] rnd;
        repeat (cycles) begin
            @(negedge clk_i);
            rnd = $urandom;
            tx_ctrl_i.data    = rnd[15:0];
            tx_ctrl_i.rwds    = rnd[17:16];
            tx_ctrl_i.data_oe = rnd[18];
            tx_ctrl_i.rwds_oe = rnd[19];
            tx_ctrl_i.clk_ena = rnd[20];
            cs_ena_i          = rnd[21];
            cs_i              = rnd[NumChips+23:24];
            hyper_rwds_i      = rnd[30];
            rwds_sample_ena_i = ($urandom_range(sample_odds - 1) == 0);
        end
    endtask

    // ============================================================
    // Checkers
    // ============================================================

    // TX outputs, high phase at posedge + 1 and low phase at negedge + 1
    always @(posedge clk_i) begin
        if (!rst_ni) begin
            ck_ena_prev  = 1'b0;
            sample_model = 1'b0;
        end else begin
            tx_cap = tx_ctrl_i;
            // Selected chips go low, all stay high without the enable
            if (cs_ena_i) begin
                cs_exp = ~cs_i;
            end else begin
                cs_exp = '1;
            end
            if (rwds_sample_ena_i) begin
                sample_model = hyper_rwds_i;
            end
            #1;
            if (rst_ni) begin
                check_value("dq high phase", tx_cap.data[15:8], hyper_o.dq);
                check_value("rwds high phase", tx_cap.rwds[1], hyper_o.rwds);
                check_value("dq_oe", tx_cap.data_oe, hyper_o.dq_oe);
                check_value("rwds_oe", tx_cap.rwds_oe, hyper_o.rwds_oe);
                check_value("hyper_cs_no", cs_exp, hyper_cs_no);
                check_value("rwds_sample_o", sample_model, rwds_sample_o);
                check_value("ck high phase", ck_ena_prev, hyper_o.ck);
                check_value("ck_n high phase", !ck_ena_prev, hyper_o.ck_n);
            end
            @(negedge clk_i);
            #1;
            if (rst_ni) begin
                check_value("dq low phase", tx_cap.data[7:0], hyper_o.dq);
                check_value("rwds low phase", tx_cap.rwds[0], hyper_o.rwds);
                check_value("ck low phase", 0, hyper_o.ck);
            end
            ck_ena_prev = rst_ni ? tx_cap.clk_ena : 1'b0;
        end
    end

    // A word leaves at the next posedge when valid and ready are both high
    always @(negedge clk_i) begin
        #1;
        if (rst_ni && rx_valid_o && rx_ready_i) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: word %0h delivered while none was expected", test_name, rx_data_o);
            end else begin
                check_value("rx word", exp_q[0], rx_data_o);
                void'(exp_q.pop_front());
            end
        end
    end

    always @(negedge clk_i) begin
        case (ready_mode)
            0: rx_ready_i = 1'b0;
            1: rx_ready_i = ($urandom_range(2) != 0);
            default: rx_ready_i = 1'b1;
        endcase
    end

    ck_n_a: assert property (@(negedge clk_i) hyper_o.ck_n == !hyper_o.ck) else begin
        errors++;
        $display("ck_n is not the complement of ck");
    end

    reset_n_a: assert property (@(posedge clk_i) hyper_o.reset_n == rst_ni) else begin
        errors++;
        $display("Pad reset_n does not follow rst_ni");
    end

    ovf_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
                                   !$past(rx_overflow_o) || rx_overflow_o) else begin
        errors++;
        $display("rx_overflow_o cleared without a reset");
    end

    // ============================================================
    // Stimulus
    // ============================================================

    initial begin
        int unsigned n;
        void'($urandom(59697));
        errors            = 0;
        checks            = 0;
        ready_mode        = 0;
        rst_ni            = 1'b0;
        cs_i              = '0;
        cs_ena_i          = 1'b0;
        tx_ctrl_i         = '0;
        rwds_sample_ena_i = 1'b0;
        rx_ctrl_i         = '0;
        rx_ready_i        = 1'b0;
        hyper_rwds_i      = 1'b0;
        hyper_dq_i        = '0;

        test_name = "reset";
        apply_reset();

        test_name = "tx_ddr_cs_clock";
        drive_tx(TxCycles / 2, 2);
        test_name = "rwds_sample_hold";
        drive_tx(TxCycles / 2, 5);
        @(negedge clk_i);
        rwds_sample_ena_i = 1'b0;
        hyper_rwds_i      = 1'b0;

        // Bursts stay short enough that a stale write-side read pointer never looks full
        test_name = "rx_backpressure";
        for (int unsigned b = 0; b < RxBursts; b++) begin
            ready_mode = 1;
            set_window(1'b1);
            strobe_burst(1 + $urandom_range(5), 1'b1);
            set_window(1'b0);
            wait_drain(BurstCycles);
        end

        test_name = "rx_window_closed";
        ready_mode = 2;
        strobe_burst(Depth, 1'b0);
        repeat (4 * SyncStages + 4) @(negedge clk_i);

        test_name = "rx_overflow";
        apply_reset();
        ready_mode = 0;
        set_window(1'b1);
        strobe_burst(Depth + 4, 1'b1);
        while (exp_q.size() > Depth) begin
            void'(exp_q.pop_back());
        end
        set_window(1'b0);
        n = 0;
        while (!rx_overflow_o && n < 4 * SyncStages) begin
            @(negedge clk_i);
            n++;
        end
        check_value("rx_overflow_o set", 1, rx_overflow_o);
        ready_mode = 2;
        wait_drain(BurstCycles);
        repeat (8) @(negedge clk_i);
        check_value("rx_overflow_o held", 1, rx_overflow_o);
        apply_reset();

        $display("Checks: %0d  Errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
hdl/hyperbus_pkg.sv
hdl/hyperbus_ddr_out.sv
hdl/hyperbus_cdc_fifo.sv
hdl/hyperbus_tx.sv
hdl/hyperbus_rx.sv
hdl/hyperbus_trx.sv
testbench/tb_hyperbus_trx.sv
